//--- pixel_arb_cfg.svh
// Pixel arbiter configuration
// Array geometry, address widths and group counter width shared by
// the packages and the RTL of the first-level address-event readout

`ifndef PIXEL_ARB_CFG_SVH
`define PIXEL_ARB_CFG_SVH

// Pixel array geometry
`define PIX_ROWS    4                   // Rows in the pixel matrix
`define PIX_COLS    4                   // Columns in the pixel matrix

// Address field widths
`define PIX_ROW_AW  2                   // Bits to address one row
`define PIX_COL_AW  2                   // Bits to address one column

// Group numbering
`define PIX_GRP_W   8                   // Wrapping group counter width

`endif

//--- arb_types_pkg.sv
// Arbitration control types
// Holds the state encoding of the level sequencer FSM so that the
// RTL and the bound properties agree on one definition

package arb_types_pkg;

    // Level sequencer FSM states
    // IDLE waits for enable and a request, ROW_GRANT picks the next
    // row of the snapshot, COL_GRANT walks that row one pixel per cycle
    typedef enum logic [1:0]
    {
        IDLE      = 2'b00,              // No group in progress
        ROW_GRANT = 2'b01,              // Row arbitration cycle
        COL_GRANT = 2'b10               // Column grants for chosen row
    } level_state_t;

endpackage : arb_types_pkg

//--- pixel_event_pkg.sv
// Pixel data types
// Request and grant matrix, pixel address and the tagged address
// event produced by the readout

`include "pixel_arb_cfg.svh"

package pixel_event_pkg;

    // One bit per pixel, indexed [row][col]
    typedef logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] pix_matrix_t;

    // Pixel address as carried on the event bus
    typedef struct packed
    {
        logic [`PIX_ROW_AW-1:0] row;    // Row index
        logic [`PIX_COL_AW-1:0] col;    // Column index
    } pix_addr_t;

    // Address event tagged with its group number
    typedef struct packed
    {
        pix_addr_t              addr;   // Granted pixel
        logic [`PIX_GRP_W-1:0]  grp;    // Group the grant belongs to
    } pix_event_t;

endpackage : pixel_event_pkg

//--- row_arbiter.sv
// Row arbiter
// Round-robin search over the per-row pending flags of the snapshot.
// The search starts at a rotating pointer that moves past each picked
// row and keeps its value from one group to the next

`timescale 1ns/1ps

`include "pixel_arb_cfg.svh"

module row_arbiter
(
    input  logic                    clk_i,          // System clock
    input  logic                    reset_i,        // Async reset, active high
    input  logic                    pick_i,         // Take the found row
    input  logic [`PIX_ROWS-1:0]    row_pend_i,     // Row has pending pixels
    output logic [`PIX_ROW_AW-1:0]  row_o,          // Chosen row index
    output logic                    found_o         // Some row is pending
);

    logic [`PIX_ROW_AW-1:0] ptr_q;                  // Highest priority row

    // Scan from the top offset down so the lowest offset wins
    always_comb
    begin
        int idx;

        row_o   = ptr_q;                            // Default when none pending
        found_o = 1'b0;
        for (int i = `PIX_ROWS - 1; i >= 0; i--)
        begin
            idx = (int'(ptr_q) + i) % `PIX_ROWS;    // Wrap around the array
            if (row_pend_i[idx])
            begin
                row_o   = idx[`PIX_ROW_AW-1:0];
                found_o = 1'b1;
            end
        end
    end

    // Pointer moves one past the granted row
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            ptr_q <= '0;                            // Row 0 first after reset
        else if (pick_i && found_o)
        begin
            if (row_o == `PIX_ROW_AW'(`PIX_ROWS - 1))
                ptr_q <= '0;                        // Wrap past last row
            else
                ptr_q <= row_o + 1'b1;
        end
    end

endmodule : row_arbiter

//--- column_arbiter.sv
// Column arbiter
// Loads the pending columns of the chosen row into a working mask and
// grants them one per step, lowest column first, clearing each bit as
// it is granted

`timescale 1ns/1ps

`include "pixel_arb_cfg.svh"

module column_arbiter
(
    input  logic                    clk_i,          // System clock
    input  logic                    reset_i,        // Async reset, active high
    input  logic                    load_i,         // Capture row_bits_i
    input  logic [`PIX_COLS-1:0]    row_bits_i,     // Pending columns of row
    input  logic                    step_i,         // Grant one column
    output logic [`PIX_COL_AW-1:0]  col_o,          // Granted column index
    output logic                    gnt_o,          // Column granted this cycle
    output logic                    last_o          // Granted bit is the final one
);

    logic [`PIX_COLS-1:0] mask_q;                   // Columns still to grant

    // Lowest set bit of the mask, scanned downward so it wins last
    always_comb
    begin
        col_o = '0;
        for (int j = `PIX_COLS - 1; j >= 0; j--)
        begin
            if (mask_q[j])
                col_o = j[`PIX_COL_AW-1:0];
        end
    end

    assign gnt_o  = step_i & (|mask_q);             // Only when something left
    // Exactly one bit set means this grant empties the mask
    assign last_o = (|mask_q) && ((mask_q & (mask_q - 1'b1)) == '0);

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            mask_q <= '0;
        else if (load_i)
            mask_q <= row_bits_i;                   // New row from snapshot
        else if (gnt_o)
            mask_q[col_o] <= 1'b0;                  // Drop the granted column
    end

endmodule : column_arbiter

//--- pixel_level.sv
// Pixel level sequencer
// Captures the pending requests as a group snapshot, then walks it row
// by row with the round-robin row arbiter and column by column with the
// column arbiter. Drives the one-hot grant matrix and the grant address,
// and pulses grp_done_o once the snapshot is empty

`timescale 1ns/1ps

`include "pixel_arb_cfg.svh"

module pixel_level
    import arb_types_pkg::*, pixel_event_pkg::*;
(
    input  logic        clk_i,                      // System clock
    input  logic        reset_i,                    // Async reset, active high
    input  logic        enable_i,                   // Level enable from above
    input  pix_matrix_t req_i,                      // Live pixel requests
    output pix_matrix_t gnt_o,                      // One-hot pixel grant
    output logic        gnt_valid_o,                // Grant strobe
    output pix_addr_t   gnt_addr_o,                 // Address of granted pixel
    output logic        grp_done_o,                 // Snapshot fully served
    output logic        active_o                    // Group in progress
);

    level_state_t               state_q, state_d;   // Sequencer FSM
    pix_matrix_t                snap_q;             // Group snapshot
    logic [`PIX_ROWS-1:0]       row_pend;           // Per-row OR of snapshot
    logic [`PIX_ROW_AW-1:0]     row_sel;            // Row from row arbiter
    logic                       row_found;
    logic [`PIX_ROW_AW-1:0]     cur_row_q;          // Row being granted
    logic [`PIX_COL_AW-1:0]     col_idx;            // Column from column arbiter
    logic                       col_gnt;
    logic                       col_last;
    logic                       pick, load, step;   // Arbiter controls

    always_comb
    begin
        for (int i = 0; i < `PIX_ROWS; i++)
            row_pend[i] = |snap_q[i];               // Row still has pending bits
    end

    // Next state and arbiter strobes
    always_comb
    begin
        state_d    = state_q;
        pick       = 1'b0;
        load       = 1'b0;
        step       = 1'b0;
        grp_done_o = 1'b0;
        case (state_q)
            IDLE:
                if (enable_i && (|req_i))
                    state_d = ROW_GRANT;            // Snapshot taken this edge
            ROW_GRANT:
                if (!enable_i)
                    state_d = IDLE;                 // Abort, no release
                else if (row_found)
                begin
                    pick    = 1'b1;
                    load    = 1'b1;
                    state_d = COL_GRANT;
                end
                else
                begin
                    grp_done_o = 1'b1;              // Snapshot empty
                    state_d    = IDLE;
                end
            COL_GRANT:
                if (!enable_i)
                    state_d = IDLE;
                else
                begin
                    step = 1'b1;                    // One grant per cycle
                    if (!col_gnt || col_last)
                        state_d = ROW_GRANT;        // Row exhausted
                end
            default:
                state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q  <= IDLE;
            active_o <= 1'b0;
        end
        else
        begin
            state_q  <= state_d;
            active_o <= (state_d != IDLE);          // Tracks the FSM state
        end
    end

    // Snapshot capture and per-grant clearing
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            snap_q <= '0;
        else if (!enable_i)
            snap_q <= '0;                           // Aborted group is dropped
        else if (state_q == IDLE)
            snap_q <= req_i;
        else if (col_gnt)
            snap_q[cur_row_q][col_idx] <= 1'b0;
    end

    always_ff @(posedge clk_i)
    begin
        if (load)
            cur_row_q <= row_sel;                   // Hold row for COL_GRANT
    end

    // Grant decode
    always_comb
    begin
        gnt_o = '0;
        if (col_gnt)
            gnt_o[cur_row_q][col_idx] = 1'b1;
    end

    assign gnt_valid_o = col_gnt;
    assign gnt_addr_o  = '{row: cur_row_q, col: col_idx};

    row_arbiter i_row_arbiter
    (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .pick_i     (pick),
        .row_pend_i (row_pend),
        .row_o      (row_sel),
        .found_o    (row_found)
    );

    column_arbiter i_column_arbiter
    (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .load_i     (load),
        .row_bits_i (snap_q[row_sel]),              // Row the arbiter just found
        .step_i     (step),
        .col_o      (col_idx),
        .gnt_o      (col_gnt),
        .last_o     (col_last)
    );

endmodule : pixel_level

//--- event_encoder.sv
// Event encoder
// Registers each grant as an address event tagged with the current
// group number and turns grp_done into the group release strobe

`timescale 1ns/1ps

`include "pixel_arb_cfg.svh"

module event_encoder
    import pixel_event_pkg::*;
(
    input  logic        clk_i,                      // System clock
    input  logic        reset_i,                    // Async reset, active high
    input  logic        gnt_valid_i,                // Grant strobe
    input  pix_addr_t   gnt_addr_i,                 // Granted pixel
    input  logic        grp_done_i,                 // Group finished
    output logic        event_valid_o,              // Event strobe
    output pix_event_t  event_o,                    // Tagged address event
    output logic        grp_release_o               // Group release strobe
);

    logic [`PIX_GRP_W-1:0] grp_cnt_q;               // Current group number

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            event_valid_o <= 1'b0;
            grp_release_o <= 1'b0;
            grp_cnt_q     <= '0;                    // First group is 0
        end
        else
        begin
            event_valid_o <= gnt_valid_i;
            grp_release_o <= grp_done_i;
            if (grp_done_i)
                grp_cnt_q <= grp_cnt_q + 1'b1;      // Wraps at PIX_GRP_W
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (gnt_valid_i)
            event_o <= '{addr: gnt_addr_i, grp: grp_cnt_q};
    end

endmodule : event_encoder

//--- pixel_arbiter_top.sv
// Pixel arbiter top level
// First-level address-event readout of the pixel array. The level
// sequencer grants pixels and the encoder turns grants into events

`timescale 1ns/1ps

module pixel_arbiter_top
    import pixel_event_pkg::*;
(
    input  logic        clk_i,                      // System clock
    input  logic        reset_i,                    // Async reset, active high
    input  logic        enable_i,                   // Level enable
    input  pix_matrix_t req_i,                      // Pixel request levels
    output pix_matrix_t gnt_o,                      // One-hot pixel grant
    output logic        event_valid_o,              // Event strobe
    output pix_event_t  event_o,                    // Address event
    output logic        grp_release_o,              // Group release pulse
    output logic        active_o,                   // Group in progress
    output logic        req_o                       // Any pixel requesting
);

    logic      gnt_valid;
    pix_addr_t gnt_addr;
    logic      grp_done;

    assign req_o = |req_i;                          // Any request to upper level

    pixel_level i_pixel_level
    (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .enable_i    (enable_i),
        .req_i       (req_i),
        .gnt_o       (gnt_o),
        .gnt_valid_o (gnt_valid),
        .gnt_addr_o  (gnt_addr),
        .grp_done_o  (grp_done),
        .active_o    (active_o)
    );

    event_encoder i_event_encoder
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .gnt_valid_i   (gnt_valid),
        .gnt_addr_i    (gnt_addr),
        .grp_done_i    (grp_done),
        .event_valid_o (event_valid_o),
        .event_o       (event_o),
        .grp_release_o (grp_release_o)
    );

endmodule : pixel_arbiter_top

//--- pixel_arbiter_props.sv
// Pixel arbiter properties
// Concurrent checks on the grant matrix and the event and release
// strobes at the top level ports, bound into the top level

`timescale 1ns/1ps

module pixel_arbiter_props
    import pixel_event_pkg::*;
(
    input  logic        clk_i,                      // System clock
    input  logic        reset_i,                    // Async reset, active high
    input  pix_matrix_t req_i,                      // Pixel requests
    input  pix_matrix_t gnt_i,                      // Pixel grants
    input  logic        event_valid_i,              // Event strobe
    input  logic        grp_release_i               // Group release strobe
);

    // At most one pixel granted per cycle
    gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_i))
        else $error("More than one pixel granted");

    // Only requesting pixels are granted
    gnt_has_req: assert property (@(posedge clk_i) disable iff (reset_i) (gnt_i & ~req_i) == '0)
        else $error("Grant to a pixel without a request");

    // Every event comes from a grant one cycle earlier
    event_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
        event_valid_i |-> $past(|gnt_i))
        else $error("Event without a grant in the previous cycle");

    release_no_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
        !(grp_release_i && (|gnt_i)))
        else $error("Group release together with a grant");

endmodule : pixel_arbiter_props

bind pixel_arbiter_top pixel_arbiter_props i_pixel_arbiter_props
(
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (req_i),
    .gnt_i         (gnt_o),
    .event_valid_i (event_valid_o),
    .grp_release_i (grp_release_o)
);

//--- pixel_arbiter_tb.sv
// Pixel arbiter testbench
// Random pixel model that drops each request once granted, and a
// reference model that expands every group snapshot into the expected
// per-cycle sequence of row picks, grants and group end

`timescale 1ns/1ps

`include "pixel_arb_cfg.svh"

module pixel_arbiter_tb
    import pixel_event_pkg::*;
();

    localparam int RAND_GROUPS = 12;                // Groups in the random group test
    localparam int LONG_CYCLES = 600;               // Cycles of the long random run
    localparam int GROUP_COUNT = 1 + RAND_GROUPS + 2 + 2;
    localparam int CYCLE_LIMIT = 40 * GROUP_COUNT + LONG_CYCLES + 400;

    typedef enum logic [1:0] {SLOT_ROW, SLOT_GNT, SLOT_DONE} slot_kind_t;

    // One expected cycle of a group
    typedef struct packed
    {
        slot_kind_t kind;
        pix_addr_t  addr;
    } slot_t;

    logic        clk_i;
    logic        reset_i;
    logic        enable_i;
    pix_matrix_t req_i;
    pix_matrix_t gnt_o;
    logic        event_valid_o;
    pix_event_t  event_o;
    logic        grp_release_o;
    logic        active_o;
    logic        req_o;

    integer                 seed = 32'h3fc9_83ef;
    slot_t                  sched[$];               // Expected cycles of the open group
    logic [`PIX_ROW_AW-1:0] model_ptr = '0;         // Model row pointer
    logic [`PIX_GRP_W-1:0]  model_grp = '0;         // Model group number
    logic                   exp_ev_valid = 1'b0;    // Expected on the next cycle
    pix_event_t             exp_event;
    logic                   exp_rel = 1'b0;
    pix_matrix_t            gnt_seen = '0;          // Grants seen by the pixels
    pix_event_t             last_event;
    int                     ev_count = 0;
    int                     rel_count = 0;
    int                     errors = 0;
    int                     err_mark = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;

    pixel_arbiter_top i_pixel_arbiter_top
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (enable_i),
        .req_i         (req_i),
        .gnt_o         (gnt_o),
        .event_valid_o (event_valid_o),
        .event_o       (event_o),
        .grp_release_o (grp_release_o),
        .active_o      (active_o),
        .req_o         (req_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;                  // 4 ns period
    end

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    function automatic slot_t make_slot(input slot_kind_t kind, input logic [1:0] row,
                                        input logic [1:0] col);
        slot_t s;

        s.kind     = kind;
        s.addr.row = row;
        s.addr.col = col;
        return s;
    endfunction

    // Rows from the pointer with wrap, columns ascending, then group end
    function automatic void schedule_group(input pix_matrix_t snap);
        pix_matrix_t            left;
        logic [`PIX_ROW_AW-1:0] r;

        left = snap;
        r    = model_ptr;
        while (left != '0)
        begin
            while (left[r] == '0)
                r = r + `PIX_ROW_AW'(1);            // Skip empty rows
            sched.push_back(make_slot(SLOT_ROW, r, '0));
            for (int c = 0; c < `PIX_COLS; c++)
            begin
                if (left[r][c])
                    sched.push_back(make_slot(SLOT_GNT, r, `PIX_COL_AW'(c)));
            end
            left[r] = '0;
            r       = r + `PIX_ROW_AW'(1);          // Next search starts past it
        end
        sched.push_back(make_slot(SLOT_DONE, '0, '0));
    endfunction

    function automatic pix_matrix_t rand_matrix(input int pct);
        pix_matrix_t m;
        logic [31:0] rnd;

        m = '0;
        for (int r = 0; r < `PIX_ROWS; r++)
        begin
            for (int c = 0; c < `PIX_COLS; c++)
            begin
                rnd     = $random(seed);
                m[r][c] = (rnd % 32'd100) < 32'(pct);   // Percent chance per pixel
            end
        end
        return m;
    endfunction

    // Mid-cycle compare of all outputs against the model
    task automatic check_cycle();
        slot_t       slot;
        pix_matrix_t exp_gnt;
        logic        busy;

        busy    = (sched.size() != 0);
        exp_gnt = '0;
        if (event_valid_o !== exp_ev_valid)
            report_error($sformatf("event_valid_o %b, expected %b", event_valid_o, exp_ev_valid));
        else if (exp_ev_valid && (event_o !== exp_event))
            report_error($sformatf("event_o %h, expected %h", event_o, exp_event));
        if (grp_release_o !== exp_rel)
            report_error($sformatf("grp_release_o %b, expected %b", grp_release_o, exp_rel));
        if (active_o !== busy)
            report_error($sformatf("active_o %b, expected %b", active_o, busy));
        if (req_o !== (|req_i))
            report_error($sformatf("req_o %b with req_i %h", req_o, req_i));
        exp_ev_valid = 1'b0;
        exp_rel      = 1'b0;
        if (busy && enable_i)
        begin
            slot = sched.pop_front();
            case (slot.kind)
                SLOT_ROW:
                    model_ptr = slot.addr.row + `PIX_ROW_AW'(1);
                SLOT_GNT:
                begin
                    exp_gnt[slot.addr.row][slot.addr.col] = 1'b1;
                    exp_ev_valid   = 1'b1;          // Event one cycle later
                    exp_event.addr = slot.addr;
                    exp_event.grp  = model_grp;
                end
                default:
                begin
                    exp_rel   = 1'b1;
                    model_grp = model_grp + `PIX_GRP_W'(1);
                end
            endcase
        end
        else if (busy)
            sched.delete();                         // Abort, no release
        else if (enable_i && (|req_i))
            schedule_group(req_i);                  // Snapshot at this edge
        if (gnt_o !== exp_gnt)
            report_error($sformatf("gnt_o %h, expected %h", gnt_o, exp_gnt));
        if (event_valid_o)
        begin
            ev_count++;
            last_event = event_o;
        end
        if (grp_release_o)
            rel_count++;
        gnt_seen = gnt_o;
    endtask

    always @(negedge clk_i)
    begin
        if (!reset_i)
            check_cycle();
    end

    // Pixels drop granted requests and raise the new ones
    task automatic drive_cycle(input logic en, input pix_matrix_t add);
        @(posedge clk_i);
        #1;
        req_i    = (req_i & ~gnt_seen) | add;
        enable_i = en;
    endtask

    task automatic wait_release(input int rel0);
        while (rel_count == rel0)
            drive_cycle(1'b1, '0);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_mark)
            tests_failed++;
        $display("Test %s done with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial
    begin : main
        pix_matrix_t            a;
        pix_matrix_t            b;
        logic [31:0]            rnd;
        logic [`PIX_GRP_W-1:0]  grp_before;
        int                     ev0;
        int                     rel0;

        reset_i  = 1'b1;
        enable_i = 1'b0;
        req_i    = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        if ((gnt_o !== '0) || (event_valid_o !== 1'b0) || (grp_release_o !== 1'b0) ||
            (active_o !== 1'b0))
            report_error("Outputs active during reset");
        @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        for (int i = 0; i < 6; i++)
        begin
            @(posedge clk_i);
            #1;
            req_i = rand_matrix(30);                // Enable low, nothing granted
        end
        drive_cycle(1'b0, '0);
        req_i = '0;
        end_test("reset");

        rnd = $random(seed);
        a   = '0;
        a[rnd[1:0]][rnd[3:2]] = 1'b1;
        ev0  = ev_count;
        rel0 = rel_count;
        drive_cycle(1'b1, a);
        wait_release(rel0);
        if (ev_count - ev0 != 1)
            report_error($sformatf("%0d events for a single pixel", ev_count - ev0));
        if ((last_event.addr.row != rnd[1:0]) || (last_event.addr.col != rnd[3:2]) ||
            (last_event.grp != '0))
            report_error($sformatf("Single pixel event %h", last_event));
        end_test("single pixel");

        for (int g = 0; g < RAND_GROUPS; g++)
        begin
            a = rand_matrix(40);
            if (a == '0)
                a[0][0] = 1'b1;
            ev0  = ev_count;
            rel0 = rel_count;
            drive_cycle(1'b1, a);
            wait_release(rel0);
            if (ev_count - ev0 != $countones(a))
                report_error($sformatf("Group %0d served %0d of %0d pixels", g,
                                       ev_count - ev0, $countones(a)));
        end
        end_test("random groups");

        a    = (rand_matrix(40) | 16'h0001) & 16'h7fff;
        b    = (rand_matrix(40) & ~a) | 16'h8000;   // Disjoint from the first group
        ev0  = ev_count;
        rel0 = rel_count;
        drive_cycle(1'b1, a);
        while (ev_count == ev0)
            drive_cycle(1'b1, '0);
        drive_cycle(1'b1, b);
        wait_release(rel0);
        if (ev_count - ev0 != $countones(a))
            report_error("Late requests served in the running group");
        ev0  = ev_count;
        rel0 = rel_count;
        wait_release(rel0);
        if (ev_count - ev0 != $countones(b))
            report_error("Late requests missing from the next group");
        end_test("late requests");

        a    = rand_matrix(60) | 16'h0110;          // Pixels in two rows at least
        ev0  = ev_count;
        rel0 = rel_count;
        drive_cycle(1'b1, a);
        while (ev_count == ev0)
            drive_cycle(1'b1, '0);
        grp_before = model_grp;                     // Number of the open group
        drive_cycle(1'b0, '0);
        drive_cycle(1'b0, '0);
        if (rel_count != rel0)
            report_error("Group release after enable drop");
        wait_release(rel0);
        if (ev_count - ev0 != $countones(a))
            report_error("Pending pixels lost across the abort");
        if (last_event.grp != grp_before)
            report_error("Group number changed across the abort");
        end_test("enable drop");

        for (int i = 0; i < LONG_CYCLES; i++)
        begin
            rnd = $random(seed);
            drive_cycle(rnd[3:0] != 4'd0, rand_matrix(4));  // Short enable drops
        end
        while (req_i != '0)
            drive_cycle(1'b1, '0);
        repeat (4) drive_cycle(1'b1, '0);
        end_test("long random run");

        $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial
    begin : watchdog
        int cycles;

        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Finished with errors");
        $finish;
    end

endmodule : pixel_arbiter_tb

//--- sources.f
+incdir+.
arb_types_pkg.sv
pixel_event_pkg.sv
row_arbiter.sv
column_arbiter.sv
pixel_level.sv
event_encoder.sv
pixel_arbiter_top.sv
pixel_arbiter_props.sv
pixel_arbiter_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the pixel arbiter testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module pixel_arbiter_tb

if ./obj_dir/Vpixel_arbiter_tb | tee /dev/stderr | grep -qxF "Finished with no errors"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
